/* project.f */
+incdir+include
hw/csr_pkg.sv
hw/priv_pkg.sv
hw/csr_counters.sv
hw/csr_file.sv
hw/trap_ctrl.sv
hw/csr_unit.sv
test/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module csr_unit_tb -o csr_unit_sim &&
./obj_dir/csr_unit_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* test/csr_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "csr_params.svh"

module csr_unit_tb import csr_pkg::*, priv_pkg::*; ();

    localparam int MAX_CYCLES = 4000;

    logic             clk;
    logic             rst;
    logic             csr_valid;
    logic [`ALEN-1:0] csr_pc;
    logic [11:0]      csr_addr;
    csr_funct3_e      csr_funct3;
    logic [4:0]       csr_rd;
    logic [4:0]       csr_rs1_uimm;
    logic [`XLEN-1:0] csr_rs1_data;
    logic             trap_req;
    cause_e           trap_cause;
    logic [`ALEN-1:0] trap_pc;
    logic [`XLEN-1:0] trap_tval;
    logic             mret_req;
    logic             inst_retired;
    logic [`XLEN-1:0] csr_result;
    logic             redirect_valid;
    logic [`ALEN-1:0] redirect_pc;
    priv_e            privilege_mode;
    logic             mstatus_mie;

    logic             active; // An operation is on the DUT inputs
    logic [31:0]      lfsr;
    int               cycles;
    logic [`XLEN-1:0] edge_cnt;
    // Shadow state of the reference model
    logic [`XLEN-1:0] s_mstatus;
    logic [`XLEN-1:0] s_mtvec;
    logic [`XLEN-1:0] s_mscratch;
    logic [`XLEN-1:0] s_mepc;
    logic [`XLEN-1:0] s_mcause;
    logic [`XLEN-1:0] s_mtval;
    logic [`XLEN-1:0] s_minstret;
    logic [`XLEN-1:0] cyc_off;
    priv_e            s_priv;
    logic [11:0]      reset_addrs [15] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
        CSR_MCAUSE, CSR_MTVAL, CSR_MCYCLE, CSR_MINSTRET, CSR_CYCLE, CSR_TIME, CSR_INSTRET,
        CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};

    csr_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Edge count since reset fell and run limit
    always @(posedge clk) begin
        edge_cnt <= rst ? '0 : edge_cnt + 64'd1;
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic logic [`XLEN-1:0] rand_bits(input int n);
        logic [`XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[`XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_priv(input string name, input priv_e got, input priv_e exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Returns the old CSR value and advances the shadow state by one cycle
    function automatic logic [`XLEN-1:0] model_csr(output logic exp_rv,
            output logic [`ALEN-1:0] exp_rpc, output logic exp_chk);
        logic [`XLEN-1:0] old;
        logic [`XLEN-1:0] src;
        logic [`XLEN-1:0] nv;
        logic             known;
        logic             rwf;
        logic             wr;
        logic             illegal;
        logic             trap;
        known = 1'b1;
        case (csr_addr)
            CSR_MSTATUS:  old = s_mstatus;
            CSR_MTVEC:    old = s_mtvec;
            CSR_MSCRATCH: old = s_mscratch;
            CSR_MEPC:     old = s_mepc;
            CSR_MCAUSE:   old = s_mcause;
            CSR_MTVAL:    old = s_mtval;
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME: old = edge_cnt + cyc_off;
            CSR_MINSTRET, CSR_INSTRET:       old = s_minstret;
            CSR_MVENDORID: old = `MVENDORID;
            CSR_MARCHID:   old = `MARCHID;
            CSR_MIMPID:    old = `MIMPID;
            CSR_MHARTID:   old = '0;
            default: begin
                known = 1'b0;
                old = '0;
            end
        endcase
        rwf = (csr_funct3 == CSR_RW) || (csr_funct3 == CSR_RWI);
        wr = rwf || (csr_rs1_uimm != 5'd0);
        src = csr_funct3[2] ? {59'd0, csr_rs1_uimm} : csr_rs1_data;
        case (csr_funct3)
            CSR_RS, CSR_RSI: nv = old | src;
            CSR_RC, CSR_RCI: nv = old & ~src;
            default:         nv = src;
        endcase
        illegal = !known || (csr_addr[11:10] == 2'b11 && wr)
                || (s_priv == PRIV_USER && csr_addr[9:8] != 2'b00);
        trap = trap_req || (csr_valid && illegal);
        exp_chk = csr_valid && !trap_req && !illegal && !(rwf && csr_rd == 5'd0);
        exp_rv = trap || mret_req;
        exp_rpc = trap ? {s_mtvec[`XLEN-1:2], 2'b00} : s_mepc;
        if (inst_retired)
            s_minstret = s_minstret + 64'd1; // A counter write below overrides
        if (trap) begin
            s_mcause = trap_req ? {60'd0, trap_cause} : 64'd2;
            s_mepc = trap_req ? trap_pc : csr_pc;
            s_mtval = trap_req ? trap_tval : '0;
            s_mstatus[7] = s_mstatus[3];
            s_mstatus[3] = 1'b0;
            s_mstatus[12:11] = s_priv;
            s_priv = PRIV_MACHINE;
        end else if (mret_req) begin
            s_priv = priv_e'(s_mstatus[12:11]);
            s_mstatus[3] = s_mstatus[7];
            s_mstatus[7] = 1'b1;
            s_mstatus[12:11] = 2'b00;
        end else if (csr_valid && wr) begin
            case (csr_addr)
                CSR_MSTATUS: s_mstatus = {51'd0, {2{nv[12] & nv[11]}}, 3'd0, nv[7], 3'd0,
                                          nv[3], 3'd0};
                CSR_MTVEC:    s_mtvec = nv & ~64'h2;
                CSR_MSCRATCH: s_mscratch = nv;
                CSR_MEPC:     s_mepc = nv & ~64'h1;
                CSR_MCAUSE:   s_mcause = nv;
                CSR_MTVAL:    s_mtval = nv;
                CSR_MCYCLE:   cyc_off = nv - edge_cnt - 64'd1; // Reads nv after the edge
                CSR_MINSTRET: s_minstret = nv;
                default: ;
            endcase
        end
        return old;
    endfunction

    always @(negedge clk) begin
        logic [`XLEN-1:0] exp_res;
        logic [`ALEN-1:0] exp_rpc;
        logic             exp_rv;
        logic             exp_chk;
        if (active) begin
            check_priv("privilege_mode", privilege_mode, s_priv);
            check_word("mstatus_mie", {63'd0, mstatus_mie}, {63'd0, s_mstatus[3]});
            exp_res = model_csr(exp_rv, exp_rpc, exp_chk);
            if (exp_chk)
                check_word("csr_result", csr_result, exp_res);
            check_word("redirect_valid", {63'd0, redirect_valid}, {63'd0, exp_rv});
            if (exp_rv)
                check_word("redirect_pc", redirect_pc, exp_rpc);
        end else if (!rst) begin
            check_word("redirect_valid", {63'd0, redirect_valid}, 64'd0);
        end
    end

    task automatic issue(input logic v, input logic [11:0] a, input csr_funct3_e f,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [`XLEN-1:0] d,
            input logic t, input logic m);
        @(posedge clk);
        active <= 1'b1;
        csr_valid <= v;
        csr_pc <= rand_bits(64) & ~64'h3;
        csr_addr <= a;
        csr_funct3 <= f;
        csr_rd <= rd;
        csr_rs1_uimm <= rs1;
        csr_rs1_data <= d;
        trap_req <= t;
        trap_cause <= cause_e'(4'(rand_bits(3)));
        trap_pc <= rand_bits(64);
        trap_tval <= rand_bits(64);
        mret_req <= m;
        inst_retired <= (rand_bits(1) != 0);
    endtask

    task automatic csr_op(input logic [11:0] a, input csr_funct3_e f, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [`XLEN-1:0] d);
        issue(1'b1, a, f, rd, rs1, d, 1'b0, 1'b0);
    endtask

    task automatic rand_op();
        logic [11:0]      a;
        logic [2:0]       f;
        logic [4:0]       rs1;
        logic [`XLEN-1:0] d;
        case (2'(rand_bits(2)))
            2'd0:    a = CSR_MSCRATCH;
            2'd1:    a = CSR_MTVEC;
            2'd2:    a = CSR_MEPC;
            default: a = CSR_MSTATUS;
        endcase
        f = 3'(rand_bits(3));
        if (f[1:0] == 2'b00)
            f[1:0] = 2'b01;
        rs1 = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
        d = (rs1 == 5'd0) ? '0 : rand_bits(64); // x0 reads as zero
        csr_op(a, csr_funct3_e'(f), 5'(rand_bits(5)), rs1, d);
    endtask

    initial begin
        lfsr = 32'd72333;
        cycles = 0;
        edge_cnt = '0;
        active = 1'b0;
        rst = 1'b1;
        csr_valid = 1'b0;
        csr_pc = '0;
        csr_addr = '0;
        csr_funct3 = CSR_RW;
        csr_rd = '0;
        csr_rs1_uimm = '0;
        csr_rs1_data = '0;
        trap_req = 1'b0;
        trap_cause = CAUSE_ILLEGAL_INSTR;
        trap_pc = '0;
        trap_tval = '0;
        mret_req = 1'b0;
        inst_retired = 1'b0;
        s_mstatus = 64'h1800;
        {s_mtvec, s_mscratch, s_mepc, s_mcause, s_mtval, s_minstret, cyc_off} = '0;
        s_priv = PRIV_MACHINE;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        foreach (reset_addrs[i])
            csr_op(reset_addrs[i], CSR_RS, 5'd1, 5'd0, '0);
        repeat (300) rand_op();

        // Illegal accesses
        csr_op(CSR_MTVEC, CSR_RW, 5'd1, 5'd3, 64'h0000_0000_8000_1003);
        csr_op(CSR_MHARTID, CSR_RW, 5'd1, 5'd4, 64'h55);
        csr_op(CSR_MCAUSE, CSR_RS, 5'd2, 5'd0, '0);
        csr_op(CSR_MEPC, CSR_RS, 5'd2, 5'd0, '0);
        csr_op(12'h7C0, CSR_RS, 5'd2, 5'd0, '0); // Unknown address
        csr_op(CSR_MSTATUS, CSR_RS, 5'd2, 5'd0, '0);

        // Pipeline trap beats the CSR write and mret
        issue(1'b1, CSR_MSCRATCH, CSR_RW, 5'd1, 5'd6, 64'hDEAD_BEEF, 1'b1, 1'b1);
        csr_op(CSR_MSCRATCH, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MCAUSE, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MTVAL, CSR_RS, 5'd1, 5'd0, '0);

        // Drop to user mode
        csr_op(CSR_MSTATUS, CSR_RC, 5'd1, 5'd7, 64'h1800);
        issue(1'b0, '0, CSR_RW, 5'd0, 5'd0, '0, 1'b0, 1'b1);
        csr_op(CSR_CYCLE, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MSCRATCH, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MSTATUS, CSR_RS, 5'd1, 5'd0, '0);

        csr_op(CSR_MINSTRET, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MCYCLE, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MCYCLE, CSR_RW, 5'd1, 5'd8, 64'h1_0000);
        csr_op(CSR_MINSTRET, CSR_RW, 5'd1, 5'd9, 64'h200);
        repeat (5) csr_op(CSR_INSTRET, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_MCYCLE, CSR_RS, 5'd1, 5'd0, '0);
        csr_op(CSR_TIME, CSR_RS, 5'd1, 5'd0, '0);

        @(posedge clk);
        active <= 1'b0;
        csr_valid <= 1'b0;
        trap_req <= 1'b0;
        mret_req <= 1'b0;
        inst_retired <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "csr_params.svh"

module csr_unit import csr_pkg::*, priv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             csr_valid,
    input  logic [`ALEN-1:0] csr_pc,
    input  logic [11:0]      csr_addr,
    input  csr_funct3_e      csr_funct3,
    input  logic [4:0]       csr_rd,
    input  logic [4:0]       csr_rs1_uimm,
    input  logic [`XLEN-1:0] csr_rs1_data,
    input  logic             trap_req,
    input  cause_e           trap_cause,
    input  logic [`ALEN-1:0] trap_pc,
    input  logic [`XLEN-1:0] trap_tval,
    input  logic             mret_req,
    input  logic             inst_retired,
    output logic [`XLEN-1:0] csr_result,
    output logic             redirect_valid,
    output logic [`ALEN-1:0] redirect_pc,
    output priv_e            privilege_mode,
    output logic             mstatus_mie
);

    // Control handshake between datapath and trap logic
    logic             csr_illegal;
    logic             csr_is_write;
    logic             csr_commit;
    logic             take_trap;
    cause_e           trap_cause_q;
    logic [`ALEN-1:0] trap_epc;
    logic [`XLEN-1:0] trap_val;
    logic             do_mret;
    priv_e            new_mpp;

    // State fed back to the trap logic
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    priv_e            mpp;

    logic             cnt_wr_cycle;
    logic             cnt_wr_instret;
    logic [`XLEN-1:0] cnt_wdata;
    logic [`XLEN-1:0] mcycle;
    logic [`XLEN-1:0] minstret;

    trap_ctrl u_trap_ctrl (.*);

    csr_file u_csr_file (.*);

    csr_counters u_csr_counters (.*);

endmodule

`default_nettype wire

/* hw/trap_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "csr_params.svh"

module trap_ctrl import priv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             csr_valid,
    input  logic [`ALEN-1:0] csr_pc,
    input  logic             csr_illegal,
    input  logic             csr_is_write,
    input  logic             trap_req,
    input  cause_e           trap_cause,
    input  logic [`ALEN-1:0] trap_pc,
    input  logic [`XLEN-1:0] trap_tval,
    input  logic             mret_req,
    input  logic [`XLEN-1:0] mtvec,
    input  logic [`XLEN-1:0] mepc,
    input  priv_e            mpp,
    output logic             csr_commit,
    output logic             take_trap,
    output cause_e           trap_cause_q,
    output logic [`ALEN-1:0] trap_epc,
    output logic [`XLEN-1:0] trap_val,
    output logic             do_mret,
    output priv_e            new_mpp,
    output priv_e            privilege_mode,
    output logic             redirect_valid,
    output logic [`ALEN-1:0] redirect_pc
);

    priv_e priv_q;
    logic  illegal_trap;

    // Pipeline trap > illegal CSR > mret > CSR write
    assign illegal_trap = !trap_req && csr_valid && csr_illegal;
    assign take_trap = trap_req || illegal_trap;
    assign do_mret = !take_trap && mret_req;
    assign csr_commit = csr_valid && csr_is_write && !csr_illegal && !trap_req && !mret_req;

    // Illegal access reports no tval
    assign trap_cause_q = trap_req ? trap_cause : CAUSE_ILLEGAL_INSTR;
    assign trap_epc = trap_req ? trap_pc : csr_pc;
    assign trap_val = trap_req ? trap_tval : '0;
    assign new_mpp = priv_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv_q <= PRIV_MACHINE;
        end else if (take_trap) begin
            priv_q <= PRIV_MACHINE;
        end else if (do_mret) begin
            priv_q <= mpp;
        end
    end

    assign privilege_mode = priv_q;

    assign redirect_valid = take_trap || do_mret;
    assign redirect_pc = take_trap ? {mtvec[`ALEN-1:2], 2'b00} : mepc; // Direct mode only

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "csr_params.svh"

module csr_file import csr_pkg::*, priv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [11:0]      csr_addr,
    input  csr_funct3_e      csr_funct3,
    input  logic [4:0]       csr_rd,
    input  logic [4:0]       csr_rs1_uimm,
    input  logic [`XLEN-1:0] csr_rs1_data,
    input  priv_e            privilege_mode,
    input  logic             csr_commit,
    input  logic             take_trap,
    input  cause_e           trap_cause_q,
    input  logic [`ALEN-1:0] trap_epc,
    input  logic [`XLEN-1:0] trap_val,
    input  priv_e            new_mpp,
    input  logic             do_mret,
    input  logic [`XLEN-1:0] mcycle,
    input  logic [`XLEN-1:0] minstret,
    output logic [`XLEN-1:0] csr_result,
    output logic             csr_illegal,
    output logic             csr_is_write,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc,
    output priv_e            mpp,
    output logic             mstatus_mie,
    output logic             cnt_wr_cycle,
    output logic             cnt_wr_instret,
    output logic [`XLEN-1:0] cnt_wdata
);

    mstatus_u         mstatus_q;
    mstatus_u         mstatus_wr;
    mstatus_u         mstatus_masked;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mtval_q;
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] wsrc;
    logic [`XLEN-1:0] wdata;
    logic             addr_known;
    logic             rw_form;

    always_comb begin
        addr_known = 1'b1;
        case (csr_addr)
            CSR_MSTATUS:          rdata = mstatus_q.raw;
            CSR_MTVEC:            rdata = mtvec_q;
            CSR_MSCRATCH:         rdata = mscratch_q;
            CSR_MEPC:             rdata = mepc_q;
            CSR_MCAUSE:           rdata = mcause_q;
            CSR_MTVAL:            rdata = mtval_q;
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME: rdata = mcycle;
            CSR_MINSTRET, CSR_INSTRET:       rdata = minstret;
            CSR_MVENDORID:        rdata = `MVENDORID;
            CSR_MARCHID:          rdata = `MARCHID;
            CSR_MIMPID:           rdata = `MIMPID;
            CSR_MHARTID:          rdata = '0; // Single hart
            default: begin
                addr_known = 1'b0;
                rdata = '0;
            end
        endcase
    end

    assign rw_form = (csr_funct3 == CSR_RW) || (csr_funct3 == CSR_RWI);
    // S/C with a zero operand never write
    assign csr_is_write = rw_form || (csr_rs1_uimm != 5'd0);
    assign csr_result = (rw_form && csr_rd == 5'd0) ? 'x : rdata;

    assign csr_illegal = !addr_known
                       || (csr_addr[11:10] == 2'b11 && csr_is_write)
                       || (privilege_mode == PRIV_USER && csr_addr[9:8] != 2'b00);

    assign wsrc = csr_funct3[2] ? {{(`XLEN-5){1'b0}}, csr_rs1_uimm} : csr_rs1_data;

    always_comb begin
        case (csr_funct3)
            CSR_RS, CSR_RSI: wdata = rdata | wsrc;
            CSR_RC, CSR_RCI: wdata = rdata & ~wsrc;
            default:         wdata = wsrc;
        endcase
    end

    // Only MIE, MPIE and MPP are writable and MPP is either U or M
    always_comb begin
        mstatus_wr.raw = wdata;
        mstatus_masked.raw = '0;
        mstatus_masked.f.mie = mstatus_wr.f.mie;
        mstatus_masked.f.mpie = mstatus_wr.f.mpie;
        mstatus_masked.f.mpp = (mstatus_wr.f.mpp == PRIV_MACHINE) ? PRIV_MACHINE : PRIV_USER;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q.raw <= 'h1800; // MPP = M
            mtvec_q <= '0;
            mscratch_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
        end else if (take_trap) begin
            mcause_q <= {{(`XLEN-4){1'b0}}, trap_cause_q};
            mepc_q <= trap_epc;
            mtval_q <= trap_val;
            mstatus_q.f.mpie <= mstatus_q.f.mie;
            mstatus_q.f.mie <= 1'b0;
            mstatus_q.f.mpp <= new_mpp;
        end else if (do_mret) begin
            mstatus_q.f.mie <= mstatus_q.f.mpie;
            mstatus_q.f.mpie <= 1'b1;
            mstatus_q.f.mpp <= PRIV_USER;
        end else if (csr_commit) begin
            case (csr_addr)
                CSR_MSTATUS:  mstatus_q <= mstatus_masked;
                CSR_MTVEC:    mtvec_q <= {wdata[`XLEN-1:2], 1'b0, wdata[0]};
                CSR_MSCRATCH: mscratch_q <= wdata;
                CSR_MEPC:     mepc_q <= {wdata[`XLEN-1:1], 1'b0};
                CSR_MCAUSE:   mcause_q <= wdata;
                CSR_MTVAL:    mtval_q <= wdata;
                default: ;    // Counters live in csr_counters
            endcase
        end
    end

    assign cnt_wr_cycle = csr_commit && (csr_addr == CSR_MCYCLE);
    assign cnt_wr_instret = csr_commit && (csr_addr == CSR_MINSTRET);
    assign cnt_wdata = wdata;

    assign mtvec = mtvec_q;
    assign mepc = mepc_q;
    assign mpp = mstatus_q.f.mpp;
    assign mstatus_mie = mstatus_q.f.mie;

endmodule

`default_nettype wire

/* hw/csr_counters.sv */
`timescale 1ns/10ps
`default_nettype none
`include "csr_params.svh"

module csr_counters (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_retired,
    input  logic             cnt_wr_cycle,
    input  logic             cnt_wr_instret,
    input  logic [`XLEN-1:0] cnt_wdata,
    output logic [`XLEN-1:0] mcycle,
    output logic [`XLEN-1:0] minstret
);

    logic [`XLEN-1:0] mcycle_q;
    logic [`XLEN-1:0] minstret_q;

    // Counts every edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q <= '0;
        end else if (cnt_wr_cycle) begin
            mcycle_q <= cnt_wdata; // Software write wins
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_q <= '0;
        end else if (cnt_wr_instret) begin
            minstret_q <= cnt_wdata;
        end else if (inst_retired) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    assign mcycle = mcycle_q;
    assign minstret = minstret_q;

endmodule

`default_nettype wire

/* hw/priv_pkg.sv */
`default_nettype none
`include "csr_params.svh"

package priv_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Synchronous exception codes
    typedef enum logic [3:0] {
        CAUSE_INSTR_MISALIGNED = 4'd0,
        CAUSE_INSTR_FAULT      = 4'd1,
        CAUSE_ILLEGAL_INSTR    = 4'd2,
        CAUSE_BREAKPOINT       = 4'd3,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_LOAD_FAULT       = 4'd5,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_STORE_FAULT      = 4'd7,
        CAUSE_ECALL_U          = 4'd8,
        CAUSE_ECALL_M          = 4'd11
    } cause_e;

    typedef struct packed {
        logic [`XLEN-14:0] rsvd_hi;
        priv_e             mpp;      // 12:11
        logic [2:0]        rsvd_10_8;
        logic              mpie;     // 7
        logic [2:0]        rsvd_6_4;
        logic              mie;      // 3
        logic [2:0]        rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_fields_t  f;
    } mstatus_u;

endpackage

`default_nettype wire

/* hw/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        // User read-only aliases of the counters
        CSR_CYCLE     = 12'hC00,
        CSR_TIME      = 12'hC01, // Mirrors mcycle as there is no real-time clock
        CSR_INSTRET   = 12'hC02,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // Bit 2 selects the uimm form
    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_funct3_e;

endpackage

`default_nettype wire

/* include/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Datapath widths
`define XLEN 64
`define ALEN 64

// Values returned by the read-only identity CSRs
`define MVENDORID 64'h0000_0000_0000_0000
`define MARCHID   64'h0000_0000_0000_0019
`define MIMPID    64'h0000_0000_0000_0102

`endif
